//--- dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int addr_w = 32;
    localparam int line_w = 256;
    localparam int word_w = 32;
    localparam int offset_w = 5;     // byte offset within a line
    localparam int word_sel_w = 3;   // 8 words per line

    typedef logic [line_w-1:0] line_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cpu_op_e;

    typedef enum logic [2:0] {
        idle      = 3'd0,
        lookup    = 3'd1,
        swap      = 3'd2,
        writeback = 3'd3,
        fill_req  = 3'd4,
        fill_wait = 3'd5,
        respond   = 3'd6
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- victim_if.sv
`timescale 1ns/1ps
`default_nettype none

interface victim_if;

    // controller side
    logic [dcache_pkg::addr_w-1:0] lookup_addr;
    logic                          insert_en;
    logic [dcache_pkg::addr_w-1:0] insert_addr;
    dcache_pkg::line_t             insert_data;
    logic                          insert_dirty;
    logic                          extract_en;

    // buffer side
    logic                          hit;
    logic                          hit_way;
    dcache_pkg::line_t             hit_data;
    logic                          hit_dirty;
    logic                          lru_valid;
    logic                          lru_dirty;
    logic [dcache_pkg::addr_w-1:0] lru_addr;
    dcache_pkg::line_t             lru_data;

    modport ctrl (
        output lookup_addr, insert_en, insert_addr, insert_data, insert_dirty, extract_en,
        input  hit, hit_way, hit_data, hit_dirty, lru_valid, lru_dirty, lru_addr, lru_data
    );

    modport buffer (
        input  lookup_addr, insert_en, insert_addr, insert_data, insert_dirty, extract_en,
        output hit, hit_way, hit_data, hit_dirty, lru_valid, lru_dirty, lru_addr, lru_data
    );

endinterface

`default_nettype wire

//--- dcache_main_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_main_array #(
    parameter int sets = 8,
    localparam int index_w = $clog2(sets),
    localparam int tag_w = dcache_pkg::addr_w - dcache_pkg::offset_w - index_w
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic [index_w-1:0]                index,
    input  wire logic [tag_w-1:0]                  tag,
    input  wire logic                              line_we,
    input  wire dcache_pkg::line_t                 line_in,
    input  wire logic                              line_dirty,
    input  wire logic                              word_we,
    input  wire logic [dcache_pkg::word_sel_w-1:0] word_sel,
    input  wire logic [dcache_pkg::word_w-1:0]     word_in,
    output logic                                   hit,
    output dcache_pkg::line_t                      line_out,
    output logic [tag_w-1:0]                       line_tag,
    output logic                                   line_valid,
    output logic                                   line_dirty_out
);

    logic [sets-1:0]   valid;
    logic [sets-1:0]   dirty;
    logic [tag_w-1:0]  tag_mem [sets];
    dcache_pkg::line_t data_mem [sets];

    assign line_valid     = valid[index];
    assign line_dirty_out = dirty[index];
    assign line_tag       = tag_mem[index];
    assign line_out       = data_mem[index];
    assign hit            = line_valid && (line_tag == tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (line_we) begin
            valid[index] <= 1'b1;
            dirty[index] <= line_dirty;
        end else if (word_we) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= line_in;
        end else if (word_we) begin
            // merge one word into the stored line
            data_mem[index][word_sel*dcache_pkg::word_w +: dcache_pkg::word_w] <= word_in;
        end
    end

endmodule

`default_nettype wire

//--- victim_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module victim_buffer (
    input  wire logic clk,
    input  wire logic rst,
    victim_if.buffer  vif
);

    localparam int la_w = dcache_pkg::addr_w - dcache_pkg::offset_w;  // line address bits

    logic [la_w-1:0]   line_addr [2];
    dcache_pkg::line_t data [2];
    logic [1:0]        valid;
    logic [1:0]        dirty;
    logic              lru;       // way replaced next
    logic [1:0]        match;
    logic              ins_way;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid[w] &&
                       (line_addr[w] == vif.lookup_addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w]);
        end
    end

    assign vif.hit       = |match;
    assign vif.hit_way   = match[1];
    assign vif.hit_data  = data[vif.hit_way];
    assign vif.hit_dirty = dirty[vif.hit_way];

    assign vif.lru_valid = valid[lru];
    assign vif.lru_dirty = dirty[lru];
    assign vif.lru_addr  = {line_addr[lru], {dcache_pkg::offset_w{1'b0}}};
    assign vif.lru_data  = data[lru];

    // on a swap the main line takes the extracted slot
    assign ins_way = vif.extract_en ? vif.hit_way : lru;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            lru   <= 1'b0;
        end else if (vif.insert_en) begin
            valid[ins_way] <= 1'b1;
            dirty[ins_way] <= vif.insert_dirty;
            lru            <= ~ins_way;  // newest line is mru
        end else if (vif.extract_en) begin
            valid[vif.hit_way] <= 1'b0;
            lru                <= vif.hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (vif.insert_en) begin
            line_addr[ins_way] <= vif.insert_addr[dcache_pkg::addr_w-1:dcache_pkg::offset_w];
            data[ins_way]      <= vif.insert_data;
        end
    end

endmodule

`default_nettype wire

//--- dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int sets = 8,
    parameter int wb_credits = 2,
    localparam int index_w = $clog2(sets),
    localparam int tag_w = dcache_pkg::addr_w - dcache_pkg::offset_w - index_w,
    localparam int cnt_w = $clog2(wb_credits + 1)
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire logic                              req_valid,
    input  wire dcache_pkg::cpu_op_e               req_op,
    input  wire logic [dcache_pkg::addr_w-1:0]     req_addr,
    input  wire logic [dcache_pkg::word_w-1:0]     req_wdata,
    output logic                                   req_ready,
    output logic                                   resp_valid,
    output logic [dcache_pkg::word_w-1:0]          resp_data,
    output logic                                   fill_req,
    output logic [dcache_pkg::addr_w-1:0]          fill_addr,
    input  wire logic                              fill_valid,
    input  wire dcache_pkg::line_t                 fill_data,
    output logic                                   wb_valid,
    output logic [dcache_pkg::addr_w-1:0]          wb_addr,
    output dcache_pkg::line_t                      wb_data,
    input  wire logic                              wb_credit,
    output logic [index_w-1:0]                     index,
    output logic [tag_w-1:0]                       tag,
    output logic                                   line_we,
    output dcache_pkg::line_t                      line_in,
    output logic                                   line_dirty,
    output logic                                   word_we,
    output logic [dcache_pkg::word_sel_w-1:0]      word_sel,
    output logic [dcache_pkg::word_w-1:0]          word_in,
    input  wire logic                              hit,
    input  wire dcache_pkg::line_t                 line_out,
    input  wire logic [tag_w-1:0]                  line_tag,
    input  wire logic                              line_valid,
    input  wire logic                              line_dirty_out,
    victim_if.ctrl                                 vif
);

    dcache_pkg::ctrl_state_e           state;
    dcache_pkg::ctrl_state_e           state_nx;
    dcache_pkg::cpu_op_e               op_q;
    logic [dcache_pkg::addr_w-1:0]     addr_q;
    logic [dcache_pkg::word_w-1:0]     wdata_q;
    logic [cnt_w-1:0]                  credit_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::idle;
        end else begin
            state <= state_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready && req_valid) begin
            op_q    <= req_op;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    always_comb begin
        state_nx = state;
        unique case (state)
            dcache_pkg::idle:      if (req_valid) state_nx = dcache_pkg::lookup;
            dcache_pkg::lookup: begin
                if (hit) begin
                    state_nx = dcache_pkg::respond;
                end else if (vif.hit) begin
                    state_nx = dcache_pkg::swap;
                end else if (line_valid && vif.lru_valid && vif.lru_dirty) begin
                    state_nx = dcache_pkg::writeback;  // lru slot must be flushed first
                end else begin
                    state_nx = dcache_pkg::fill_req;
                end
            end
            dcache_pkg::swap:      state_nx = dcache_pkg::respond;
            dcache_pkg::writeback: if (credit_cnt != '0) state_nx = dcache_pkg::fill_req;
            dcache_pkg::fill_req:  state_nx = dcache_pkg::fill_wait;
            dcache_pkg::fill_wait: if (fill_valid) state_nx = dcache_pkg::respond;
            dcache_pkg::respond:   state_nx = dcache_pkg::idle;
            default:               state_nx = dcache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= cnt_w'(wb_credits);
        end else begin
            credit_cnt <= credit_cnt - cnt_w'(wb_valid) + cnt_w'(wb_credit);
        end
    end

    // cpu side
    assign req_ready  = (state == dcache_pkg::idle);
    assign resp_valid = (state == dcache_pkg::respond);
    assign resp_data  = line_out[word_sel*dcache_pkg::word_w +: dcache_pkg::word_w];  // pre-write word

    // memory side
    assign fill_req  = (state == dcache_pkg::fill_req);
    assign fill_addr = {addr_q[dcache_pkg::addr_w-1:dcache_pkg::offset_w],
                        {dcache_pkg::offset_w{1'b0}}};
    assign wb_valid  = (state == dcache_pkg::writeback) && (credit_cnt != '0);
    assign wb_addr   = vif.lru_addr;
    assign wb_data   = vif.lru_data;

    // main array always addressed by the held request
    assign index      = addr_q[dcache_pkg::offset_w +: index_w];
    assign tag        = addr_q[dcache_pkg::addr_w-1 -: tag_w];
    assign word_sel   = addr_q[dcache_pkg::offset_w-1 -: dcache_pkg::word_sel_w];
    assign word_in    = wdata_q;
    assign word_we    = resp_valid && (op_q == dcache_pkg::op_write);
    assign line_we    = (state == dcache_pkg::swap) ||
                        (state == dcache_pkg::fill_wait && fill_valid);
    assign line_in    = (state == dcache_pkg::swap) ? vif.hit_data : fill_data;
    assign line_dirty = (state == dcache_pkg::swap) && vif.hit_dirty;  // fills come in clean

    // victim buffer gets the displaced main line
    assign vif.lookup_addr  = addr_q;
    assign vif.insert_en    = line_valid &&
                              (state == dcache_pkg::swap || state == dcache_pkg::fill_req);
    assign vif.insert_addr  = {line_tag, index, {dcache_pkg::offset_w{1'b0}}};
    assign vif.insert_data  = line_out;
    assign vif.insert_dirty = line_dirty_out;
    assign vif.extract_en   = (state == dcache_pkg::swap);

endmodule

`default_nettype wire

//--- dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int sets = 8,
    parameter int wb_credits = 2
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req_valid,
    input  wire dcache_pkg::cpu_op_e           req_op,
    input  wire logic [dcache_pkg::addr_w-1:0] req_addr,
    input  wire logic [dcache_pkg::word_w-1:0] req_wdata,
    output logic                               req_ready,
    output logic                               resp_valid,
    output logic [dcache_pkg::word_w-1:0]      resp_data,
    output logic                               fill_req,
    output logic [dcache_pkg::addr_w-1:0]      fill_addr,
    input  wire logic                          fill_valid,
    input  wire dcache_pkg::line_t             fill_data,
    output logic                               wb_valid,
    output logic [dcache_pkg::addr_w-1:0]      wb_addr,
    output dcache_pkg::line_t                  wb_data,
    input  wire logic                          wb_credit
);

    localparam int index_w = $clog2(sets);
    localparam int tag_w = dcache_pkg::addr_w - dcache_pkg::offset_w - index_w;

    // controller to main array
    logic [index_w-1:0]                index;
    logic [tag_w-1:0]                  tag;
    logic                              line_we;
    dcache_pkg::line_t                 line_in;
    logic                              line_dirty;
    logic                              word_we;
    logic [dcache_pkg::word_sel_w-1:0] word_sel;
    logic [dcache_pkg::word_w-1:0]     word_in;
    logic                              hit;
    dcache_pkg::line_t                 line_out;
    logic [tag_w-1:0]                  line_tag;
    logic                              line_valid;
    logic                              line_dirty_out;

    victim_if vif ();

    dcache_main_array #(.sets(sets)) main_i (.*);

    victim_buffer victim_i (.*);

    dcache_ctrl #(
        .sets       (sets),
        .wb_credits (wb_credits)
    ) ctrl_i (.*);

endmodule

`default_nettype wire

//--- dcache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts #(
    parameter int wb_credits = 2
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic req_valid,
    input wire logic req_ready,
    input wire logic resp_valid,
    input wire logic fill_valid,
    input wire logic wb_valid,
    input wire logic wb_credit
);

    int   credits;            // credits seen from the port traffic
    logic busy;               // accepted and not yet answered
    logic credit_err = 1'b0;
    logic resp_err = 1'b0;
    logic ready_err = 1'b0;
    logic fill_err = 1'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= wb_credits;
            busy    <= 1'b0;
        end else begin
            credits <= credits - int'(wb_valid) + int'(wb_credit);
            if (req_valid && req_ready) begin
                busy <= 1'b1;
            end else if (resp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    credit_ok: assert property (@(posedge clk) disable iff (rst) wb_valid |-> credits > 0)
        else begin
            $error("wb_valid fired with no credit left");
            credit_err = 1'b1;
        end

    resp_pulse: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
        else begin
            $error("resp_valid high for two cycles");
            resp_err = 1'b1;
        end

    ready_low: assert property (@(posedge clk) disable iff (rst) busy |-> !req_ready)
        else begin
            $error("req_ready high while a request is open");
            ready_err = 1'b1;
        end

    fill_resp: assert property (@(posedge clk) disable iff (rst) fill_valid |=> resp_valid)
        else begin
            $error("no resp_valid after fill_valid");
            fill_err = 1'b1;
        end

endmodule

bind dcache_top dcache_asserts #(.wb_credits(wb_credits)) asserts_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .fill_valid (fill_valid),
    .wb_valid   (wb_valid),
    .wb_credit  (wb_credit)
);

`default_nettype wire

//--- tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int mem_words = 1024;  // 4 KiB backing store

    logic                clk = 1'b0;
    logic                rst;
    logic                req_valid;
    dcache_pkg::cpu_op_e req_op;
    logic [31:0]         req_addr;
    logic [31:0]         req_wdata;
    logic                req_ready;
    logic                resp_valid;
    logic [31:0]         resp_data;
    logic                fill_req;
    logic [31:0]         fill_addr;
    logic                fill_valid;
    dcache_pkg::line_t   fill_data;
    logic                wb_valid;
    logic [31:0]         wb_addr;
    dcache_pkg::line_t   wb_data;
    logic                wb_credit;

    logic [31:0] mem_img [mem_words];  // what memory holds
    logic [31:0] ref_img [mem_words];  // what the cpu should see
    logic [31:0] cur_addr = '0;        // address of the open request
    int          credit_due [$];
    int          seed = 58;
    int          credit_lat = 0;       // 0 means random 2 to 10
    int          fill_cnt = 0;
    int          wb_cnt = 0;
    string       test_name = "reset";

    dcache_top #(.sets(8), .wb_credits(2)) dut_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] pattern(input int word);
        return (32'(word) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int widx(input logic [31:0] addr);
        return int'(addr[11:2]);
    endfunction

    function automatic logic protocol_err();
        return dut_i.asserts_i.credit_err || dut_i.asserts_i.resp_err ||
               dut_i.asserts_i.ready_err || dut_i.asserts_i.fill_err;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else
            fail_now($sformatf("** Error [%s] %s: expected %h, actual %h",
                               test_name, what, exp, got));
    endtask

    // one cpu request; reads and writes both return the word held before the request
    task automatic access(input dcache_pkg::cpu_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, output int lat);
        logic [31:0] exp;
        int          wait_cnt;
        exp       = ref_img[widx(addr)];
        cur_addr  = addr;
        wait_cnt  = 0;
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= wdata;
        do begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 100) fail_now("timeout waiting for req_ready");
        end while (!req_ready);
        if (op == dcache_pkg::op_write) ref_img[widx(addr)] = wdata;  // accepted here
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > 300) fail_now("timeout waiting for resp_valid");
        end while (!resp_valid);
        check_word(op == dcache_pkg::op_write ? "old word" : "read data", exp, resp_data);
    endtask

    initial begin : fill_model
        int                delay;
        int                base;
        dcache_pkg::line_t fill_line;
        fill_valid = 1'b0;
        fill_data  = '0;
        forever begin
            @(posedge clk);
            if (fill_req) begin
                fill_cnt++;
                check_word("fill address", {cur_addr[31:5], 5'd0}, fill_addr);
                base  = widx(fill_addr);
                delay = 1 + int'($unsigned($random(seed)) % 6);
                for (int i = 0; i < 8; i++) begin
                    fill_line[i*32 +: 32] = mem_img[base + i];
                end
                repeat (delay - 1) @(posedge clk);
                fill_valid <= 1'b1;
                fill_data  <= fill_line;
                @(posedge clk);
                fill_valid <= 1'b0;
            end
        end
    end

    initial begin : wb_model
        int now;
        int delay;
        now       = 0;
        wb_credit = 1'b0;
        for (int w = 0; w < mem_words; w++) begin
            mem_img[w] = pattern(w);
        end
        forever begin
            @(posedge clk);
            now++;
            wb_credit <= 1'b0;
            if (wb_valid) begin
                wb_cnt++;
                assert (wb_addr < 32'h1000 && wb_addr[4:0] == 5'd0) else
                    fail_now("writeback address is unaligned or outside the test range");
                for (int i = 0; i < 8; i++) begin
                    check_word("writeback data", ref_img[widx(wb_addr) + i], wb_data[i*32 +: 32]);
                    mem_img[widx(wb_addr) + i] = wb_data[i*32 +: 32];
                end
                delay = (credit_lat > 0) ? credit_lat : 2 + int'($unsigned($random(seed)) % 9);
                credit_due.push_back(now + delay);
            end
            for (int k = 0; k < credit_due.size(); k++) begin
                if (credit_due[k] <= now) begin
                    credit_due.delete(k);
                    wb_credit <= 1'b1;  // at most one credit per cycle
                    break;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (protocol_err()) fail_now("a protocol assertion on the cache ports failed");
    end

    initial begin : main
        int          lat;
        int          fills;
        int          wbs;
        int          line;
        int          wsel;
        logic [31:0] rnd;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = dcache_pkg::op_read;
        req_addr  = '0;
        req_wdata = '0;
        for (int w = 0; w < mem_words; w++) begin
            ref_img[w] = pattern(w);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (req_ready && !resp_valid && !fill_req && !wb_valid) else
            fail_now("cache outputs are not idle after reset");

        test_name = "read after reset";
        access(dcache_pkg::op_read, 32'h0000_0104, 32'h0, lat);

        test_name = "write then read hit";
        access(dcache_pkg::op_write, 32'h0000_0108, 32'hdead_beef, lat);
        access(dcache_pkg::op_read, 32'h0000_0108, 32'h0, lat);
        check_word("hit latency", 32'd2, lat);

        // 0x040, 0x140 and 0x240 share set 2
        test_name = "victim hit";
        access(dcache_pkg::op_read, 32'h0000_0040, 32'h0, lat);
        access(dcache_pkg::op_read, 32'h0000_0144, 32'h0, lat);
        access(dcache_pkg::op_read, 32'h0000_0248, 32'h0, lat);
        fills = fill_cnt;
        access(dcache_pkg::op_read, 32'h0000_004c, 32'h0, lat);
        check_word("victim hit latency", 32'd3, lat);
        check_word("fill count", fills, fill_cnt);

        test_name = "dirty writeback";
        wbs = wb_cnt;
        for (int k = 0; k < 5; k++) begin
            access(dcache_pkg::op_write, 32'h0a0 + k * 32'h104, 32'hc0de_0000 + k, lat);
        end
        assert (wb_cnt - wbs >= 2) else fail_now("dirty lines were not written back");
        for (int k = 0; k < 5; k++) begin
            access(dcache_pkg::op_read, 32'h0a0 + k * 32'h104, 32'h0, lat);
        end

        test_name = "credit back-pressure";
        credit_lat = 40;
        wbs = wb_cnt;
        for (int k = 0; k < 6; k++) begin
            access(dcache_pkg::op_write, 32'h0e0 + k * 32'h104, 32'hbeef_0000 + k, lat);
        end
        for (int k = 0; k < 6; k++) begin
            access(dcache_pkg::op_read, 32'h0e0 + k * 32'h104, 32'h0, lat);
        end
        assert (wb_cnt - wbs >= 3) else fail_now("too few writebacks to reach the credit limit");
        credit_lat = 0;

        test_name = "random mix";
        for (int n = 0; n < 300; n++) begin
            line = int'($unsigned($random(seed)) % 32);
            wsel = int'($unsigned($random(seed)) % 8);
            rnd  = $random(seed);
            if (rnd[0]) begin
                access(dcache_pkg::op_write, 32'(line * 32 + wsel * 4), $random(seed), lat);
            end else begin
                access(dcache_pkg::op_read, 32'(line * 32 + wsel * 4), 32'h0, lat);
            end
        end

        @(negedge clk);
        if (protocol_err()) begin
            fail_now("a protocol assertion on the cache ports failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- files.f
dcache_pkg.sv
victim_if.sv
dcache_main_array.sv
victim_buffer.sv
dcache_ctrl.sv
dcache_top.sv
dcache_asserts.sv
tb_dcache.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         := tb_dcache
FILELIST    := files.f
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing --assert
RUN_FLAGS   := +verilator+error+limit+100
OBJ_DIR     := obj_dir
LOG         := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
